// ==== design/mips_lite_pkg.sv ====
package mips_lite_pkg;

    // datapath widths
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_NUM    = 32;

    // boot vector in kseg1
    localparam logic [ADDR_W-1:0] RESET_PC = 32'hbfc00000;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // SPECIAL function codes, also used as the ALU operation
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // not a MIPS funct, only seen by the ALU
    localparam logic [5:0] FN_LUI  = 6'h3f;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_fmt_t;

    // one instruction word, read as R or I format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

endpackage

// ==== design/fetch_unit.sv ====
module fetch_unit
    import mips_lite_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  instr_u            rom_data_i,
    output logic              rom_en_o,
    output logic [ADDR_W-1:0] rom_addr_o,
    output logic [ADDR_W-1:0] id_pc_o,
    output instr_u            id_instr_o
);

    logic [ADDR_W-1:0] pc_q;

    assign rom_addr_o = pc_q;

    // pc only moves once the ROM has been enabled
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rom_en_o <= 1'b0;
            pc_q     <= RESET_PC;
        end else begin
            rom_en_o <= 1'b1;
            if (rom_en_o && !stall_i) begin
                pc_q <= pc_q + ADDR_W'(4);
            end
        end
    end

    // fetch/decode register
    // zero word is sll $0 and never writes
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_pc_o    <= '0;
            id_instr_o <= '0;
        end else if (!stall_i) begin
            id_pc_o    <= pc_q;
            id_instr_o <= rom_en_o ? rom_data_i : '0;
        end
    end

endmodule

// ==== design/decode_unit.sv ====
module decode_unit
    import mips_lite_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic [ADDR_W-1:0]     id_pc_i,
    input  instr_u                id_instr_i,
    output logic [REG_ADDR_W-1:0] rs_addr_o,
    output logic [REG_ADDR_W-1:0] rt_addr_o,
    output logic                  rs_en_o,
    output logic                  rt_en_o,
    input  logic [DATA_W-1:0]     rs_data_i,
    input  logic [DATA_W-1:0]     rt_data_i,
    output logic [5:0]            ex_funct_o,
    output logic [4:0]            ex_shamt_o,
    output logic [DATA_W-1:0]     ex_op1_o,
    output logic [DATA_W-1:0]     ex_op2_o,
    output logic                  ex_wr_en_o,
    output logic [REG_ADDR_W-1:0] ex_wr_addr_o,
    output logic [ADDR_W-1:0]     ex_pc_o
);

    logic [5:0]            opcode;
    logic [5:0]            funct_d;
    logic [REG_ADDR_W-1:0] dest_d;
    logic                  known_d;
    logic                  use_imm;
    logic                  imm_sext;
    logic [DATA_W-1:0]     imm_ext;
    logic [DATA_W-1:0]     op2_d;

    assign opcode    = id_instr_i.r_fmt.opcode;
    assign rs_addr_o = id_instr_i.i_fmt.rs;
    assign rt_addr_o = id_instr_i.r_fmt.rt;

    always_comb begin
        funct_d  = id_instr_i.r_fmt.funct;
        dest_d   = id_instr_i.i_fmt.rt;
        known_d  = 1'b0;
        use_imm  = 1'b0;
        imm_sext = 1'b0;
        rs_en_o  = 1'b0;
        rt_en_o  = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                dest_d = id_instr_i.r_fmt.rd;
                case (id_instr_i.r_fmt.funct)
                    // shifts take rt and shamt only
                    FN_SLL, FN_SRL, FN_SRA: begin
                        known_d = 1'b1;
                        rt_en_o = 1'b1;
                    end
                    FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT: begin
                        known_d = 1'b1;
                        rs_en_o = 1'b1;
                        rt_en_o = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_ADDIU: begin
                known_d  = 1'b1;
                rs_en_o  = 1'b1;
                use_imm  = 1'b1;
                imm_sext = 1'b1;
                funct_d  = FN_ADDU;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                known_d = 1'b1;
                rs_en_o = 1'b1;
                use_imm = 1'b1;
                funct_d = (opcode == OP_ANDI) ? FN_AND :
                          (opcode == OP_ORI)  ? FN_OR  : FN_XOR;
            end
            OP_LUI: begin
                known_d = 1'b1;
                use_imm = 1'b1;
                funct_d = FN_LUI;
            end
            default: ;
        endcase
    end

    // addiu sign extends, the logic immediates zero extend
    assign imm_ext = imm_sext ? {{(DATA_W-16){id_instr_i.i_fmt.imm[15]}}, id_instr_i.i_fmt.imm}
                              : {{(DATA_W-16){1'b0}}, id_instr_i.i_fmt.imm};
    assign op2_d   = use_imm ? imm_ext : rt_data_i;

    // decode/execute register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_wr_en_o <= 1'b0;
        end else if (!stall_i) begin
            ex_wr_en_o <= known_d && (dest_d != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ex_funct_o   <= funct_d;
            ex_shamt_o   <= id_instr_i.r_fmt.shamt;
            ex_op1_o     <= rs_data_i;
            ex_op2_o     <= op2_d;
            ex_wr_addr_o <= dest_d;
            ex_pc_o      <= id_pc_i;
        end
    end

endmodule

// ==== design/reg_file.sv ====
module reg_file
    import mips_lite_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  wr_en_i,
    input  logic [REG_ADDR_W-1:0] wr_addr_i,
    input  logic [DATA_W-1:0]     wr_data_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_a_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_b_i,
    output logic [DATA_W-1:0]     rd_data_a_o,
    output logic [DATA_W-1:0]     rd_data_b_o
);

    logic [DATA_W-1:0] regs_q [REG_NUM];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // $zero is hardwired
    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs_q[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs_q[rd_addr_b_i];

endmodule

// ==== design/operand_forward.sv ====
module operand_forward
    import mips_lite_pkg::*;
(
    input  logic                  rs_en_i,
    input  logic                  rt_en_i,
    input  logic [REG_ADDR_W-1:0] rs_addr_i,
    input  logic [REG_ADDR_W-1:0] rt_addr_i,
    input  logic [DATA_W-1:0]     rf_a_i,
    input  logic [DATA_W-1:0]     rf_b_i,
    input  logic                  ex_wr_en_i,
    input  logic [REG_ADDR_W-1:0] ex_wr_addr_i,
    input  logic [DATA_W-1:0]     ex_result_i,
    input  logic                  wb_wr_en_i,
    input  logic [REG_ADDR_W-1:0] wb_wr_addr_i,
    input  logic [DATA_W-1:0]     wb_data_i,
    output logic [DATA_W-1:0]     rs_data_o,
    output logic [DATA_W-1:0]     rt_data_o
);

    // youngest producer wins: EX, then WB, then the register file
    function automatic logic [DATA_W-1:0] select_operand(
        input logic                  rd_en,
        input logic [REG_ADDR_W-1:0] rd_addr,
        input logic [DATA_W-1:0]     rf_data,
        input logic                  ex_en,
        input logic [REG_ADDR_W-1:0] ex_addr,
        input logic [DATA_W-1:0]     ex_data,
        input logic                  wb_en,
        input logic [REG_ADDR_W-1:0] wb_addr,
        input logic [DATA_W-1:0]     wb_data
    );
        if (!rd_en || rd_addr == '0) begin
            return '0;
        end else if (ex_en && ex_addr == rd_addr) begin
            return ex_data;
        end else if (wb_en && wb_addr == rd_addr) begin
            return wb_data;
        end
        return rf_data;
    endfunction

    assign rs_data_o = select_operand(rs_en_i, rs_addr_i, rf_a_i,
                                      ex_wr_en_i, ex_wr_addr_i, ex_result_i,
                                      wb_wr_en_i, wb_wr_addr_i, wb_data_i);
    assign rt_data_o = select_operand(rt_en_i, rt_addr_i, rf_b_i,
                                      ex_wr_en_i, ex_wr_addr_i, ex_result_i,
                                      wb_wr_en_i, wb_wr_addr_i, wb_data_i);

endmodule

// ==== design/execute_unit.sv ====
module execute_unit
    import mips_lite_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic [5:0]            ex_funct_i,
    input  logic [4:0]            ex_shamt_i,
    input  logic [DATA_W-1:0]     ex_op1_i,
    input  logic [DATA_W-1:0]     ex_op2_i,
    input  logic                  ex_wr_en_i,
    input  logic [REG_ADDR_W-1:0] ex_wr_addr_i,
    input  logic [ADDR_W-1:0]     ex_pc_i,
    output logic [DATA_W-1:0]     ex_result_o,
    output logic                  wb_wr_en_o,
    output logic [REG_ADDR_W-1:0] wb_wr_addr_o,
    output logic [DATA_W-1:0]     wb_data_o,
    output logic [ADDR_W-1:0]     wb_pc_o
);

    logic signed_lt;
    logic wb_en_q;

    assign signed_lt = $signed(ex_op1_i) < $signed(ex_op2_i);

    always_comb begin
        case (ex_funct_i)
            FN_ADDU: ex_result_o = ex_op1_i + ex_op2_i;
            FN_SUBU: ex_result_o = ex_op1_i - ex_op2_i;
            FN_AND:  ex_result_o = ex_op1_i & ex_op2_i;
            FN_OR:   ex_result_o = ex_op1_i | ex_op2_i;
            FN_XOR:  ex_result_o = ex_op1_i ^ ex_op2_i;
            FN_NOR:  ex_result_o = ~(ex_op1_i | ex_op2_i);
            FN_SLT:  ex_result_o = {{(DATA_W-1){1'b0}}, signed_lt};
            // shifts operate on rt
            FN_SLL:  ex_result_o = ex_op2_i << ex_shamt_i;
            FN_SRL:  ex_result_o = ex_op2_i >> ex_shamt_i;
            FN_SRA:  ex_result_o = $signed(ex_op2_i) >>> ex_shamt_i;
            FN_LUI:  ex_result_o = {ex_op2_i[DATA_W/2-1:0], {(DATA_W/2){1'b0}}};
            default: ex_result_o = '0;
        endcase
    end

    // execute/writeback register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_en_q <= 1'b0;
        end else if (!stall_i) begin
            wb_en_q <= ex_wr_en_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_wr_addr_o <= ex_wr_addr_i;
            wb_data_o    <= ex_result_o;
            wb_pc_o      <= ex_pc_i;
        end
    end

    // held item writes once, on the first unstalled cycle
    assign wb_wr_en_o = wb_en_q && !stall_i;

endmodule

// ==== design/mips_lite_core.sv ====
module mips_lite_core
    import mips_lite_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    output logic                  rom_en_o,
    output logic [ADDR_W-1:0]     rom_addr_o,
    input  instr_u                rom_data_i,
    output logic                  debug_reg_write_en_o,
    output logic [REG_ADDR_W-1:0] debug_reg_write_addr_o,
    output logic [DATA_W-1:0]     debug_reg_write_data_o,
    output logic [ADDR_W-1:0]     debug_pc_addr_o
);

    // fetch to decode
    logic [ADDR_W-1:0]     id_pc;
    instr_u                id_instr;

    // register reads
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic                  rs_en;
    logic                  rt_en;
    logic [DATA_W-1:0]     rf_a;
    logic [DATA_W-1:0]     rf_b;
    logic [DATA_W-1:0]     rs_data;
    logic [DATA_W-1:0]     rt_data;

    // decode to execute
    logic [5:0]            ex_funct;
    logic [4:0]            ex_shamt;
    logic [DATA_W-1:0]     ex_op1;
    logic [DATA_W-1:0]     ex_op2;
    logic                  ex_wr_en;
    logic [REG_ADDR_W-1:0] ex_wr_addr;
    logic [ADDR_W-1:0]     ex_pc;
    logic [DATA_W-1:0]     ex_result;

    // writeback
    logic                  wb_wr_en;
    logic [REG_ADDR_W-1:0] wb_wr_addr;
    logic [DATA_W-1:0]     wb_data;
    logic [ADDR_W-1:0]     wb_pc;

    fetch_unit u_fetch (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .stall_i   (stall_i),
        .rom_data_i(rom_data_i),
        .rom_en_o  (rom_en_o),
        .rom_addr_o(rom_addr_o),
        .id_pc_o   (id_pc),
        .id_instr_o(id_instr)
    );

    decode_unit u_decode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .id_pc_i     (id_pc),
        .id_instr_i  (id_instr),
        .rs_addr_o   (rs_addr),
        .rt_addr_o   (rt_addr),
        .rs_en_o     (rs_en),
        .rt_en_o     (rt_en),
        .rs_data_i   (rs_data),
        .rt_data_i   (rt_data),
        .ex_funct_o  (ex_funct),
        .ex_shamt_o  (ex_shamt),
        .ex_op1_o    (ex_op1),
        .ex_op2_o    (ex_op2),
        .ex_wr_en_o  (ex_wr_en),
        .ex_wr_addr_o(ex_wr_addr),
        .ex_pc_o     (ex_pc)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (wb_wr_en),
        .wr_addr_i  (wb_wr_addr),
        .wr_data_i  (wb_data),
        .rd_addr_a_i(rs_addr),
        .rd_addr_b_i(rt_addr),
        .rd_data_a_o(rf_a),
        .rd_data_b_o(rf_b)
    );

    operand_forward u_forward (
        .rs_en_i     (rs_en),
        .rt_en_i     (rt_en),
        .rs_addr_i   (rs_addr),
        .rt_addr_i   (rt_addr),
        .rf_a_i      (rf_a),
        .rf_b_i      (rf_b),
        .ex_wr_en_i  (ex_wr_en),
        .ex_wr_addr_i(ex_wr_addr),
        .ex_result_i (ex_result),
        .wb_wr_en_i  (wb_wr_en),
        .wb_wr_addr_i(wb_wr_addr),
        .wb_data_i   (wb_data),
        .rs_data_o   (rs_data),
        .rt_data_o   (rt_data)
    );

    execute_unit u_execute (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .ex_funct_i  (ex_funct),
        .ex_shamt_i  (ex_shamt),
        .ex_op1_i    (ex_op1),
        .ex_op2_i    (ex_op2),
        .ex_wr_en_i  (ex_wr_en),
        .ex_wr_addr_i(ex_wr_addr),
        .ex_pc_i     (ex_pc),
        .ex_result_o (ex_result),
        .wb_wr_en_o  (wb_wr_en),
        .wb_wr_addr_o(wb_wr_addr),
        .wb_data_o   (wb_data),
        .wb_pc_o     (wb_pc)
    );

    // debug port mirrors the register-file write
    assign debug_reg_write_en_o   = wb_wr_en;
    assign debug_reg_write_addr_o = wb_wr_addr;
    assign debug_reg_write_data_o = wb_data;
    assign debug_pc_addr_o        = wb_pc;

endmodule

// ==== verif/mips_lite_core_properties.sv ====
module mips_lite_core_properties
    import mips_lite_pkg::*;
(
    input logic                  clk,
    input logic                  rst_n_i,
    input logic                  stall_i,
    input logic                  rom_en_o,
    input logic [ADDR_W-1:0]     rom_addr_o,
    input logic                  debug_reg_write_en_o,
    input logic [REG_ADDR_W-1:0] debug_reg_write_addr_o,
    input logic [DATA_W-1:0]     debug_reg_write_data_o,
    input logic [ADDR_W-1:0]     debug_pc_addr_o
);

    int assert_errors = 0;

    rom_off_in_reset: assert property (@(posedge clk) !rst_n_i |-> !rom_en_o)
        else begin
            assert_errors++;
            $error("rom_en_o high while in reset");
        end

    // sequential fetch, no branches
    pc_advance: assert property (@(posedge clk) disable iff (!rst_n_i)
        (rom_en_o && !stall_i) |=> rom_addr_o == $past(rom_addr_o) + ADDR_W'(4))
        else begin
            assert_errors++;
            $error("rom_addr_o did not advance by 4");
        end

    pc_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (rom_en_o && stall_i) |=> $stable(rom_addr_o))
        else begin
            assert_errors++;
            $error("rom_addr_o moved during stall");
        end

    // held writeback item must not change across a stalled edge
    wb_hold_in_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> ($stable(debug_reg_write_addr_o) && $stable(debug_reg_write_data_o)
                     && $stable(debug_pc_addr_o)))
        else begin
            assert_errors++;
            $error("writeback item changed while stalled");
        end

    no_write_r0: assert property (@(posedge clk) disable iff (!rst_n_i)
        debug_reg_write_en_o |-> debug_reg_write_addr_o != '0)
        else begin
            assert_errors++;
            $error("debug write to register 0");
        end

endmodule

bind mips_lite_core mips_lite_core_properties u_props (
    .clk                   (clk),
    .rst_n_i               (rst_n_i),
    .stall_i               (stall_i),
    .rom_en_o              (rom_en_o),
    .rom_addr_o            (rom_addr_o),
    .debug_reg_write_en_o  (debug_reg_write_en_o),
    .debug_reg_write_addr_o(debug_reg_write_addr_o),
    .debug_reg_write_data_o(debug_reg_write_data_o),
    .debug_pc_addr_o       (debug_pc_addr_o)
);

// ==== verif/tb_mips_lite_core.sv ====
module tb_mips_lite_core
    import mips_lite_pkg::*;
();

    localparam int ROM_DEPTH     = 64;
    localparam int TEST_OVERHEAD = 30;
    localparam int DRAIN_CYCLES  = 8;

    logic                  clk;
    logic                  rst_n_i;
    logic                  stall_i;
    logic                  rom_en;
    logic [ADDR_W-1:0]     rom_addr;
    instr_u                rom_data;
    logic                  dbg_en;
    logic [REG_ADDR_W-1:0] dbg_addr;
    logic [DATA_W-1:0]     dbg_data;
    logic [ADDR_W-1:0]     dbg_pc;

    instr_u                rom_mem [ROM_DEPTH];
    instr_u                prog [$];
    logic [ADDR_W-1:0]     exp_pc [$];
    logic [REG_ADDR_W-1:0] exp_addr [$];
    logic [DATA_W-1:0]     exp_data [$];

    string       cur_test;
    int          test_errors;
    int          pass_count   = 0;
    int          fail_count   = 0;
    int          cycle_budget = 20;
    int          wd_cycles    = 0;
    bit          monitor_on   = 1'b0;
    logic [31:0] lcg_state    = 32'hcdeb;

    mips_lite_core dut (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .stall_i               (stall_i),
        .rom_en_o              (rom_en),
        .rom_addr_o            (rom_addr),
        .rom_data_i            (rom_data),
        .debug_reg_write_en_o  (dbg_en),
        .debug_reg_write_addr_o(dbg_addr),
        .debug_reg_write_data_o(dbg_data),
        .debug_pc_addr_o       (dbg_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // word-addressed ROM starting at the reset vector
    logic [ADDR_W-1:0] rom_offset;
    assign rom_offset = rom_addr - RESET_PC;
    assign rom_data   = (rom_offset < ADDR_W'(4 * ROM_DEPTH)) ? rom_mem[rom_offset[7:2]] : '0;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic instr_u encode_r(input logic [5:0] funct, input int rd, input int rs,
                                        input int rt, input int shamt);
        instr_u w;
        w.r_fmt.opcode = OP_SPECIAL;
        w.r_fmt.rs     = REG_ADDR_W'(rs);
        w.r_fmt.rt     = REG_ADDR_W'(rt);
        w.r_fmt.rd     = REG_ADDR_W'(rd);
        w.r_fmt.shamt  = 5'(shamt);
        w.r_fmt.funct  = funct;
        return w;
    endfunction

    function automatic instr_u encode_i(input logic [5:0] opcode, input int rt, input int rs,
                                        input logic [15:0] imm);
        instr_u w;
        w.i_fmt.opcode = opcode;
        w.i_fmt.rs     = REG_ADDR_W'(rs);
        w.i_fmt.rt     = REG_ADDR_W'(rt);
        w.i_fmt.imm    = imm;
        return w;
    endfunction

    task automatic check_word(input string test, input string what,
                              input logic [DATA_W-1:0] expected, input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %h, actual %h", test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_reg_addr(input string test, input string what,
                                  input logic [REG_ADDR_W-1:0] expected,
                                  input logic [REG_ADDR_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %0d, actual %0d", test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // reference model, run over the whole program up front
    task automatic build_expected();
        logic [DATA_W-1:0]     model [REG_NUM];
        instr_u                w;
        logic [DATA_W-1:0]     a;
        logic [DATA_W-1:0]     b;
        logic [DATA_W-1:0]     res;
        logic [REG_ADDR_W-1:0] dest;
        logic                  writes;
        for (int r = 0; r < REG_NUM; r++) begin
            model[r] = '0;
        end
        for (int i = 0; i < prog.size(); i++) begin
            w      = prog[i];
            a      = model[w.i_fmt.rs];
            b      = model[w.r_fmt.rt];
            dest   = w.i_fmt.rt;
            writes = 1'b1;
            res    = '0;
            case (w.r_fmt.opcode)
                OP_SPECIAL: begin
                    dest = w.r_fmt.rd;
                    case (w.r_fmt.funct)
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_NOR:  res = ~(a | b);
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  res = b << w.r_fmt.shamt;
                        FN_SRL:  res = b >> w.r_fmt.shamt;
                        FN_SRA:  res = $signed(b) >>> w.r_fmt.shamt;
                        default: writes = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + {{16{w.i_fmt.imm[15]}}, w.i_fmt.imm};
                OP_ANDI:  res = a & {16'h0, w.i_fmt.imm};
                OP_ORI:   res = a | {16'h0, w.i_fmt.imm};
                OP_XORI:  res = a ^ {16'h0, w.i_fmt.imm};
                OP_LUI:   res = {w.i_fmt.imm, 16'h0};
                default:  writes = 1'b0;
            endcase
            if (writes && dest != '0) begin
                model[dest] = res;
                exp_pc.push_back(RESET_PC + ADDR_W'(4 * i));
                exp_addr.push_back(dest);
                exp_data.push_back(res);
            end
        end
    endtask

    task automatic load_rom();
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom_mem[i] = (i < prog.size()) ? prog[i] : '0;
        end
    endtask

    task automatic pulse_reset();
        next_cycle();
        rst_n_i = 1'b0;
        repeat (2) begin
            next_cycle();
            check_word(cur_test, "rom_en_o in reset", '0, DATA_W'(rom_en));
        end
        rst_n_i = 1'b1;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
        prog.delete();
    endtask

    task automatic finish_test();
        monitor_on = 1'b0;
        exp_pc.delete();
        exp_addr.delete();
        exp_data.delete();
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: ok", cur_test);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", cur_test, test_errors);
        end
    endtask

    // stall_i is high for stall_len cycles from stall_start after reset release
    task automatic run_program(input int stall_start, input int stall_len);
        int                limit;
        int                cyc;
        logic [ADDR_W-1:0] prev_addr;
        logic              stalled;
        build_expected();
        load_rom();
        cycle_budget += prog.size() + stall_len + TEST_OVERHEAD;
        pulse_reset();
        monitor_on = 1'b1;
        limit = prog.size() + stall_len + 12;
        cyc   = 0;
        while (exp_pc.size() != 0 && cyc < limit) begin
            stall_i   = (cyc >= stall_start) && (cyc < stall_start + stall_len);
            prev_addr = rom_addr;
            stalled   = stall_i && rom_en;
            next_cycle();
            cyc++;
            if (stalled) begin
                check_word(cur_test, "rom_addr_o during stall", prev_addr, rom_addr);
            end
        end
        stall_i = 1'b0;
        if (exp_pc.size() != 0) begin
            $display("test %s: %0d expected debug writes never appeared",
                     cur_test, exp_pc.size());
            test_errors++;
        end
        repeat (DRAIN_CYCLES) next_cycle();
        finish_test();
    endtask

    // every debug write must match the head of the expected queue
    always @(negedge clk) begin
        if (monitor_on && dbg_en === 1'b1) begin
            if (exp_pc.size() == 0) begin
                $display("test %s: unexpected debug write to r%0d from pc %h",
                         cur_test, dbg_addr, dbg_pc);
                test_errors++;
            end else begin
                check_word(cur_test, "debug pc", exp_pc.pop_front(), dbg_pc);
                check_reg_addr(cur_test, "write address", exp_addr.pop_front(), dbg_addr);
                check_word(cur_test, "write data", exp_data.pop_front(), dbg_data);
            end
        end
    end

    task automatic test_reset_fetch();
        start_test("reset_fetch");
        load_rom();
        cycle_budget += TEST_OVERHEAD;
        pulse_reset();
        monitor_on = 1'b1;
        next_cycle();
        check_word(cur_test, "rom_en_o after release", 32'd1, DATA_W'(rom_en));
        for (int k = 0; k < 5; k++) begin
            check_word(cur_test, "rom_addr_o", RESET_PC + ADDR_W'(4 * k), rom_addr);
            next_cycle();
        end
        repeat (DRAIN_CYCLES) next_cycle();
        finish_test();
    endtask

    task automatic test_immediates();
        start_test("immediates");
        prog.push_back(encode_i(OP_LUI, 1, 0, 16'h1234));
        prog.push_back(encode_i(OP_ORI, 1, 1, 16'h5678));
        prog.push_back(encode_i(OP_ADDIU, 2, 1, 16'hfff0));
        prog.push_back(encode_i(OP_ANDI, 3, 2, 16'h0ff0));
        prog.push_back(encode_i(OP_XORI, 4, 3, 16'haaaa));
        // negative immediate from zero
        prog.push_back(encode_i(OP_ADDIU, 5, 0, 16'h8000));
        prog.push_back(encode_i(OP_LUI, 6, 0, 16'hffff));
        prog.push_back(encode_i(OP_ADDIU, 6, 6, 16'hffff));
        run_program(0, 0);
    endtask

    // producer distances 1, 2 and 3 cover EX, WB and register file reads
    task automatic build_forward_prog();
        prog.push_back(encode_i(OP_ADDIU, 1, 0, 16'd5));
        prog.push_back(encode_i(OP_ADDIU, 2, 0, 16'd7));
        prog.push_back(encode_r(FN_ADDU, 3, 1, 2, 0));
        prog.push_back(encode_r(FN_SUBU, 4, 3, 1, 0));
        prog.push_back(encode_r(FN_OR, 5, 3, 4, 0));
        prog.push_back(encode_r(FN_XOR, 6, 3, 5, 0));
        prog.push_back(encode_r(FN_AND, 7, 6, 6, 0));
        prog.push_back(encode_r(FN_ADDU, 7, 7, 7, 0));
        prog.push_back(encode_r(FN_NOR, 8, 7, 4, 0));
    endtask

    task automatic test_forwarding();
        start_test("forwarding");
        build_forward_prog();
        run_program(0, 0);
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        int          sh;
        start_test("alu");
        for (int round = 0; round < 2; round++) begin
            a  = lcg_next();
            b  = lcg_next();
            sh = int'(lcg_next() >> 27);
            // first round: negative rs, positive rt for slt and sra
            if (round == 0) begin
                a[31] = 1'b1;
                b[31] = 1'b0;
            end
            prog.push_back(encode_i(OP_LUI, 1, 0, a[31:16]));
            prog.push_back(encode_i(OP_ORI, 1, 1, a[15:0]));
            prog.push_back(encode_i(OP_LUI, 2, 0, b[31:16]));
            prog.push_back(encode_i(OP_ORI, 2, 2, b[15:0]));
            prog.push_back(encode_r(FN_ADDU, 3, 1, 2, 0));
            prog.push_back(encode_r(FN_SUBU, 4, 1, 2, 0));
            prog.push_back(encode_r(FN_AND, 5, 1, 2, 0));
            prog.push_back(encode_r(FN_OR, 6, 1, 2, 0));
            prog.push_back(encode_r(FN_XOR, 7, 1, 2, 0));
            prog.push_back(encode_r(FN_NOR, 8, 1, 2, 0));
            prog.push_back(encode_r(FN_SLT, 9, 1, 2, 0));
            prog.push_back(encode_r(FN_SLT, 10, 2, 1, 0));
            prog.push_back(encode_r(FN_SLL, 11, 0, 1, sh));
            prog.push_back(encode_r(FN_SRL, 12, 0, 1, sh));
            prog.push_back(encode_r(FN_SRA, 13, 0, 1, sh));
        end
        run_program(0, 0);
    endtask

    task automatic test_stall();
        start_test("stall");
        build_forward_prog();
        run_program(6, 4);
    endtask

    task automatic test_noops();
        start_test("noops");
        prog.push_back(encode_i(OP_ADDIU, 1, 0, 16'd3));
        prog.push_back(encode_i(OP_ADDIU, 0, 1, 16'd9));
        prog.push_back(instr_u'(32'hfc010000));
        prog.push_back(instr_u'(32'h00000000));
        // mult is not decoded here
        prog.push_back(encode_r(6'h18, 2, 1, 1, 0));
        prog.push_back(encode_r(FN_ADDU, 2, 1, 1, 0));
        prog.push_back(instr_u'(32'h8c220000));
        prog.push_back(encode_i(OP_ADDIU, 3, 2, 16'd1));
        run_program(0, 0);
    endtask

    initial begin
        rst_n_i = 1'b1;
        stall_i = 1'b0;
        test_reset_fetch();
        test_immediates();
        test_forwarding();
        test_alu();
        test_stall();
        test_noops();
        $display("tests passed: %0d, failed: %0d, assertion errors: %0d",
                 pass_count, fail_count, dut.u_props.assert_errors);
        if (fail_count == 0 && dut.u_props.assert_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // budget grows as each test is loaded
    initial begin
        while (wd_cycles <= cycle_budget) begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("watchdog: run exceeded %0d cycles", cycle_budget);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== mips_lite_core.f ====
design/mips_lite_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/reg_file.sv
design/operand_forward.sv
design/execute_unit.sv
design/mips_lite_core.sv
verif/mips_lite_core_properties.sv
verif/tb_mips_lite_core.sv

// ==== Bender.yml ====
package:
  name: mips_lite_core

sources:
  - files:
      - design/mips_lite_pkg.sv
      - design/fetch_unit.sv
      - design/decode_unit.sv
      - design/reg_file.sv
      - design/operand_forward.sv
      - design/execute_unit.sv
      - design/mips_lite_core.sv
  - target: simulation
    files:
      - verif/mips_lite_core_properties.sv
      - verif/tb_mips_lite_core.sv
